/* logic/chimney_macros.svh */
//////////////////////////////////////////////////////////////////////
// Chimney widths and address map
// Shared by the package and the network interface RTL
//////////////////////////////////////////////////////////////////////

`ifndef CHIMNEY_MACROS_SVH
`define CHIMNEY_MACROS_SVH

// AXI channel widths
`define CHIMNEY_ADDR_W    32
`define CHIMNEY_DATA_W    32
`define CHIMNEY_AXI_ID_W  4

// NoC node addressing
`define CHIMNEY_NODE_W    4

// Region k of the map belongs to node k
`define CHIMNEY_MAP_BASE  32'h8000_0000
`define CHIMNEY_MAP_SIZE  32'h0100_0000
`define CHIMNEY_MAP_RULES 4
`define CHIMNEY_ERR_NODE  15

`endif

/* logic/chimney_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Chimney types
// AXI beat structs, flit formats and channel opcodes
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "chimney_macros.svh"

package chimney_pkg;

  // Channel carried by a flit
  typedef enum logic [2:0] {CH_AW, CH_W, CH_AR, CH_B, CH_R} axi_ch_e;

  // Which beat owns the shared AW/W arbiter input
  typedef enum logic {SEL_AW, SEL_W} aw_w_sel_e;

  typedef struct packed {
    logic [`CHIMNEY_AXI_ID_W-1:0] id;
    logic [`CHIMNEY_ADDR_W-1:0]   addr;
    logic [7:0]                   len;
  } axi_aw_t;

  typedef struct packed {
    logic [`CHIMNEY_DATA_W-1:0] data;
    logic                       last;
  } axi_w_t;

  typedef struct packed {
    logic [`CHIMNEY_AXI_ID_W-1:0] id;
    logic [`CHIMNEY_ADDR_W-1:0]   addr;
    logic [7:0]                   len;
  } axi_ar_t;

  typedef struct packed {
    logic [`CHIMNEY_AXI_ID_W-1:0] id;
    logic [1:0]                   resp;
  } axi_b_t;

  typedef struct packed {
    logic [`CHIMNEY_AXI_ID_W-1:0] id;
    logic [`CHIMNEY_DATA_W-1:0]   data;
    logic [1:0]                   resp;
    logic                         last;
  } axi_r_t;

  typedef struct packed {
    logic [`CHIMNEY_NODE_W-1:0] dst_id;
    logic [`CHIMNEY_NODE_W-1:0] src_id;
    axi_ch_e                    axi_ch;
    logic                       last;
  } flit_hdr_t;

  // Request payload is sized for AW/AR, W sits in the low bits
  typedef struct packed {
    flit_hdr_t                   hdr;
    logic [$bits(axi_aw_t)-1:0]  payload;
  } req_flit_t;

  // Response payload is sized for R, B sits in the low bits
  typedef struct packed {
    flit_hdr_t                  hdr;
    logic [$bits(axi_r_t)-1:0]  payload;
  } rsp_flit_t;

endpackage

`default_nettype wire

/* logic/addr_id_map.sv */
//////////////////////////////////////////////////////////////////////
// Address to node translation
// Fixed map of equal regions, unmapped addresses go to the error node
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "chimney_macros.svh"

module addr_id_map (
  input  logic [`CHIMNEY_ADDR_W-1:0] addr_i,
  output logic [`CHIMNEY_NODE_W-1:0] dst_o
);

  // One extra bit so the end of the last region cannot wrap
  typedef logic [`CHIMNEY_ADDR_W:0] ext_addr_t;

  localparam ext_addr_t MapBase = ext_addr_t'(`CHIMNEY_MAP_BASE);
  localparam ext_addr_t MapSize = ext_addr_t'(`CHIMNEY_MAP_SIZE);

  function automatic ext_addr_t region_start(input int unsigned k);
    return MapBase + ext_addr_t'(k) * MapSize;
  endfunction

  always_comb begin
    dst_o = `CHIMNEY_NODE_W'(`CHIMNEY_ERR_NODE);
    for (int unsigned k = 0; k < `CHIMNEY_MAP_RULES; k++) begin
      if ((ext_addr_t'(addr_i) >= region_start(k)) &&
          (ext_addr_t'(addr_i) <  region_start(k + 1))) begin
        dst_o = `CHIMNEY_NODE_W'(k);
      end
    end
  end

endmodule

`default_nettype wire

/* logic/req_flit_packer.sv */
//////////////////////////////////////////////////////////////////////
// Request flit packer
// Turns AW, W and AR beats into request flits and keeps AW and its
// W beats together on one arbiter input
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "chimney_macros.svh"

module req_flit_packer (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic [`CHIMNEY_NODE_W-1:0] node_id_i,
  // AXI manager requests
  input  chimney_pkg::axi_aw_t       aw_i,
  input  logic                       aw_valid_i,
  output logic                       aw_ready_o,
  input  chimney_pkg::axi_w_t        w_i,
  input  logic                       w_valid_i,
  output logic                       w_ready_o,
  input  chimney_pkg::axi_ar_t       ar_i,
  input  logic                       ar_valid_i,
  output logic                       ar_ready_o,
  // Arbiter sources
  output chimney_pkg::req_flit_t     aww_flit_o,
  output logic                       aww_valid_o,
  input  logic                       aww_grant_i,
  output chimney_pkg::req_flit_t     ar_flit_o,
  output logic                       ar_valid_o,
  input  logic                       ar_grant_i
);

  logic [`CHIMNEY_NODE_W-1:0] aw_dst, ar_dst;
  logic [`CHIMNEY_NODE_W-1:0] w_dst_q;
  chimney_pkg::aw_w_sel_e     sel_q, sel_d;
  chimney_pkg::req_flit_t     aw_flit, w_flit;
  logic                       aw_fire, w_fire;

  addr_id_map i_aw_map (
    .addr_i ( aw_i.addr ),
    .dst_o  ( aw_dst    )
  );

  addr_id_map i_ar_map (
    .addr_i ( ar_i.addr ),
    .dst_o  ( ar_dst    )
  );

  //////////////////////////////////////////////////////////////////////
  // Flit packing
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    aw_flit            = '0;
    aw_flit.hdr.dst_id = aw_dst;
    aw_flit.hdr.src_id = node_id_i;
    aw_flit.hdr.axi_ch = chimney_pkg::CH_AW;
    aw_flit.hdr.last   = 1'b0;
    aw_flit.payload    = aw_i;
  end

  // W follows its AW, so it reuses the stored destination
  always_comb begin
    w_flit             = '0;
    w_flit.hdr.dst_id  = w_dst_q;
    w_flit.hdr.src_id  = node_id_i;
    w_flit.hdr.axi_ch  = chimney_pkg::CH_W;
    w_flit.hdr.last    = w_i.last;
    w_flit.payload[$bits(chimney_pkg::axi_w_t)-1:0] = w_i;
  end

  always_comb begin
    ar_flit_o            = '0;
    ar_flit_o.hdr.dst_id = ar_dst;
    ar_flit_o.hdr.src_id = node_id_i;
    ar_flit_o.hdr.axi_ch = chimney_pkg::CH_AR;
    ar_flit_o.hdr.last   = 1'b1;
    ar_flit_o.payload    = ar_i;
  end

  //////////////////////////////////////////////////////////////////////
  // AW/W selection
  //////////////////////////////////////////////////////////////////////

  assign aw_fire = aw_valid_i && aw_ready_o;
  assign w_fire  = w_valid_i && w_ready_o;

  always_comb begin
    sel_d = sel_q;
    if (aw_fire) begin
      sel_d = chimney_pkg::SEL_W;
    end
    if (w_fire && w_i.last) begin
      sel_d = chimney_pkg::SEL_AW;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sel_q   <= chimney_pkg::SEL_AW;
      w_dst_q <= '0;
    end else begin
      sel_q <= sel_d;
      if (aw_fire) begin
        w_dst_q <= aw_dst;
      end
    end
  end

  assign aww_flit_o  = (sel_q == chimney_pkg::SEL_AW) ? aw_flit : w_flit;
  assign aww_valid_o = (sel_q == chimney_pkg::SEL_AW) ? aw_valid_i : w_valid_i;
  assign ar_valid_o  = ar_valid_i;

  // Grants go back to whichever beat is on the source
  assign aw_ready_o = aww_grant_i && (sel_q == chimney_pkg::SEL_AW);
  assign w_ready_o  = aww_grant_i && (sel_q == chimney_pkg::SEL_W);
  assign ar_ready_o = ar_grant_i;

endmodule

`default_nettype wire

/* logic/wormhole_arbiter.sv */
//////////////////////////////////////////////////////////////////////
// Wormhole arbiter
// Round-robin over two sources, stays on a source until its packet
// has finished
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module wormhole_arbiter (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  chimney_pkg::req_flit_t [1:0]  flit_i,
  input  logic [1:0]                    valid_i,
  output logic [1:0]                    grant_o,
  output chimney_pkg::req_flit_t        flit_o,
  output logic                          valid_o,
  input  logic                          ready_i
);

  logic prio_q, prio_d;
  logic lock_q, lock_d;
  logic hold_q, hold_d;
  logic sel_q, sel;
  logic fire;

  // Locked or stalled sources keep the link, otherwise round-robin
  always_comb begin
    if (lock_q || hold_q) begin
      sel = sel_q;
    end else if (valid_i[prio_q]) begin
      sel = prio_q;
    end else if (valid_i[!prio_q]) begin
      sel = !prio_q;
    end else begin
      sel = prio_q;
    end
  end

  assign flit_o  = flit_i[sel];
  assign valid_o = valid_i[sel];
  assign fire    = valid_o && ready_i;

  always_comb begin
    grant_o      = '0;
    grant_o[sel] = ready_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Packet tracking
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    lock_d = lock_q;
    prio_d = prio_q;
    hold_d = valid_o && !ready_i;
    if (fire) begin
      lock_d = !flit_o.hdr.last;
      // Packet done, hand priority over
      if (flit_o.hdr.last) begin
        prio_d = !sel;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prio_q <= 1'b0;
      lock_q <= 1'b0;
      hold_q <= 1'b0;
      sel_q  <= 1'b0;
    end else begin
      prio_q <= prio_d;
      lock_q <= lock_d;
      hold_q <= hold_d;
      sel_q  <= sel;
    end
  end

endmodule

`default_nettype wire

/* logic/rsp_flit_unpacker.sv */
//////////////////////////////////////////////////////////////////////
// Response flit unpacker
// Splits response flits by channel onto the AXI B and R outputs
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module rsp_flit_unpacker (
  input  chimney_pkg::rsp_flit_t rsp_flit_i,
  input  logic                   rsp_valid_i,
  output logic                   rsp_ready_o,
  output chimney_pkg::axi_b_t    b_o,
  output logic                   b_valid_o,
  input  logic                   b_ready_i,
  output chimney_pkg::axi_r_t    r_o,
  output logic                   r_valid_o,
  input  logic                   r_ready_i
);

  logic is_b, is_r;

  assign is_b = (rsp_flit_i.hdr.axi_ch == chimney_pkg::CH_B);
  assign is_r = (rsp_flit_i.hdr.axi_ch == chimney_pkg::CH_R);

  // B lives in the low payload bits
  assign b_o = chimney_pkg::axi_b_t'(rsp_flit_i.payload[$bits(chimney_pkg::axi_b_t)-1:0]);
  assign r_o = chimney_pkg::axi_r_t'(rsp_flit_i.payload);

  assign b_valid_o = rsp_valid_i && is_b;
  assign r_valid_o = rsp_valid_i && is_r;

  // Unknown opcodes are swallowed
  assign rsp_ready_o = is_b ? b_ready_i :
                       is_r ? r_ready_i : 1'b1;

endmodule

`default_nettype wire

/* logic/axi_noc_chimney.sv */
//////////////////////////////////////////////////////////////////////
// AXI NoC chimney, manager side
// Packs AXI requests onto the request link and unpacks responses
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "chimney_macros.svh"

module axi_noc_chimney (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic [`CHIMNEY_NODE_W-1:0] node_id_i,
  // AXI manager side
  input  chimney_pkg::axi_aw_t       aw_i,
  input  logic                       aw_valid_i,
  output logic                       aw_ready_o,
  input  chimney_pkg::axi_w_t        w_i,
  input  logic                       w_valid_i,
  output logic                       w_ready_o,
  input  chimney_pkg::axi_ar_t       ar_i,
  input  logic                       ar_valid_i,
  output logic                       ar_ready_o,
  output chimney_pkg::axi_b_t        b_o,
  output logic                       b_valid_o,
  input  logic                       b_ready_i,
  output chimney_pkg::axi_r_t        r_o,
  output logic                       r_valid_o,
  input  logic                       r_ready_i,
  // NoC links
  output chimney_pkg::req_flit_t     req_flit_o,
  output logic                       req_valid_o,
  input  logic                       req_ready_i,
  input  chimney_pkg::rsp_flit_t     rsp_flit_i,
  input  logic                       rsp_valid_i,
  output logic                       rsp_ready_o
);

  // Source 0 is AW/W, source 1 is AR
  chimney_pkg::req_flit_t [1:0] src_flit;
  logic [1:0]                   src_valid;
  logic [1:0]                   src_grant;

  req_flit_packer i_packer (
    .clk_i       ( clk_i        ),
    .reset_i     ( reset_i      ),
    .node_id_i   ( node_id_i    ),
    .aw_i        ( aw_i         ),
    .aw_valid_i  ( aw_valid_i   ),
    .aw_ready_o  ( aw_ready_o   ),
    .w_i         ( w_i          ),
    .w_valid_i   ( w_valid_i    ),
    .w_ready_o   ( w_ready_o    ),
    .ar_i        ( ar_i         ),
    .ar_valid_i  ( ar_valid_i   ),
    .ar_ready_o  ( ar_ready_o   ),
    .aww_flit_o  ( src_flit[0]  ),
    .aww_valid_o ( src_valid[0] ),
    .aww_grant_i ( src_grant[0] ),
    .ar_flit_o   ( src_flit[1]  ),
    .ar_valid_o  ( src_valid[1] ),
    .ar_grant_i  ( src_grant[1] )
  );

  wormhole_arbiter i_req_arbiter (
    .clk_i   ( clk_i       ),
    .reset_i ( reset_i     ),
    .flit_i  ( src_flit    ),
    .valid_i ( src_valid   ),
    .grant_o ( src_grant   ),
    .flit_o  ( req_flit_o  ),
    .valid_o ( req_valid_o ),
    .ready_i ( req_ready_i )
  );

  rsp_flit_unpacker i_unpacker (
    .rsp_flit_i  ( rsp_flit_i  ),
    .rsp_valid_i ( rsp_valid_i ),
    .rsp_ready_o ( rsp_ready_o ),
    .b_o         ( b_o         ),
    .b_valid_o   ( b_valid_o   ),
    .b_ready_i   ( b_ready_i   ),
    .r_o         ( r_o         ),
    .r_valid_o   ( r_valid_o   ),
    .r_ready_i   ( r_ready_i   )
  );

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
//////////////////////////////////////////////////////////////////////
// Testbench clock, 10 ns period
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_clock (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

/* bench/chimney_props.sv */
//////////////////////////////////////////////////////////////////////
// Chimney port properties
// Link stability and B/R output exclusivity
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module chimney_props (
  input logic                   clk_i,
  input logic                   reset_i,
  input chimney_pkg::req_flit_t req_flit_i,
  input logic                   req_valid_i,
  input logic                   req_ready_i,
  input logic                   rsp_valid_i,
  input logic                   b_valid_i,
  input logic                   r_valid_i
);

  // Number of property violations seen so far
  int assert_fails;

  // A stalled flit has to wait on the link unchanged
  req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_flit_i))
    else begin
      assert_fails++;
      $error("Request flit changed while the link was stalled");
    end

  b_r_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    !(b_valid_i && r_valid_i))
    else begin
      assert_fails++;
      $error("B and R outputs valid in the same cycle");
    end

  rsp_source: assert property (@(posedge clk_i) disable iff (reset_i)
    (b_valid_i || r_valid_i) |-> rsp_valid_i)
    else begin
      assert_fails++;
      $error("B or R output valid without an incoming response flit");
    end

endmodule

`default_nettype wire

/* bench/chimney_checker.sv */
//////////////////////////////////////////////////////////////////////
// Chimney checker
// Reference model of the request and response paths, compares the
// flits and beats seen on the DUT ports
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "chimney_macros.svh"

module chimney_checker (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       flush_i,
  input  logic [`CHIMNEY_NODE_W-1:0] node_id_i,
  input  chimney_pkg::axi_aw_t       aw_i,
  input  logic                       aw_valid_i,
  input  logic                       aw_ready_i,
  input  chimney_pkg::axi_w_t        w_i,
  input  logic                       w_valid_i,
  input  logic                       w_ready_i,
  input  chimney_pkg::axi_ar_t       ar_i,
  input  logic                       ar_valid_i,
  input  logic                       ar_ready_i,
  input  chimney_pkg::req_flit_t     req_flit_i,
  input  logic                       req_valid_i,
  input  logic                       req_ready_i,
  input  chimney_pkg::rsp_flit_t     rsp_flit_i,
  input  logic                       rsp_valid_i,
  input  logic                       rsp_ready_i,
  input  chimney_pkg::axi_b_t        b_i,
  input  logic                       b_valid_i,
  input  logic                       b_ready_i,
  input  chimney_pkg::axi_r_t        r_i,
  input  logic                       r_valid_i,
  input  logic                       r_ready_i,
  output int                         mismatches_o,
  output int                         failures_o
);

  chimney_pkg::req_flit_t     aww_q[$];
  chimney_pkg::req_flit_t     ar_q[$];
  chimney_pkg::axi_b_t        b_q[$];
  chimney_pkg::axi_r_t        r_q[$];
  logic [`CHIMNEY_NODE_W-1:0] w_dst;
  logic                       in_pkt;
  logic                       flushed;
  int                         mismatches;
  int                         failures;

  assign mismatches_o = mismatches;
  assign failures_o   = failures;

  // Four equal regions from the map base, node k owns region k
  function automatic logic [`CHIMNEY_NODE_W-1:0] node_for(input logic [31:0] addr);
    logic [31:0] offset;
    if (addr < `CHIMNEY_MAP_BASE) begin
      return `CHIMNEY_NODE_W'(`CHIMNEY_ERR_NODE);
    end
    offset = addr - `CHIMNEY_MAP_BASE;
    if (offset >= `CHIMNEY_MAP_RULES * `CHIMNEY_MAP_SIZE) begin
      return `CHIMNEY_NODE_W'(`CHIMNEY_ERR_NODE);
    end
    return `CHIMNEY_NODE_W'(offset / `CHIMNEY_MAP_SIZE);
  endfunction

  function automatic chimney_pkg::req_flit_t make_flit(input logic [3:0] dst,
                                                       input chimney_pkg::axi_ch_e ch,
                                                       input logic last,
                                                       input logic [43:0] payload);
    chimney_pkg::req_flit_t flit;
    flit.hdr.dst_id = dst;
    flit.hdr.src_id = node_id_i;
    flit.hdr.axi_ch = ch;
    flit.hdr.last   = last;
    flit.payload    = payload;
    return flit;
  endfunction

  task automatic check_req(input chimney_pkg::req_flit_t got);
    chimney_pkg::req_flit_t exp;
    logic                   is_ar;
    is_ar = (got.hdr.axi_ch == chimney_pkg::CH_AR);
    if (is_ar && in_pkt) begin
      failures++;
      $display("AR flit left between an AW flit and its last W flit at %0t", $time);
    end
    if ((is_ar && ar_q.size() == 0) || (!is_ar && aww_q.size() == 0)) begin
      failures++;
      $display("Request flit %h at %0t has no accepted beat behind it", got, $time);
      return;
    end
    exp = is_ar ? ar_q.pop_front() : aww_q.pop_front();
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: request flit expected %h, got %h", $time, exp, got);
    end
    if (got.hdr.axi_ch == chimney_pkg::CH_AW) begin
      in_pkt = 1'b1;
    end else if (got.hdr.axi_ch == chimney_pkg::CH_W && got.hdr.last) begin
      in_pkt = 1'b0;
    end
  endtask

  always @(posedge clk_i) begin
    chimney_pkg::axi_b_t exp_b;
    chimney_pkg::axi_r_t exp_r;
    if (reset_i) begin
      in_pkt  = 1'b0;
      flushed = 1'b0;
      w_dst   = '0;
    end else begin
      if (aw_valid_i && aw_ready_i) begin
        w_dst = node_for(aw_i.addr);
        aww_q.push_back(make_flit(w_dst, chimney_pkg::CH_AW, 1'b0, aw_i));
      end
      if (w_valid_i && w_ready_i) begin
        aww_q.push_back(make_flit(w_dst, chimney_pkg::CH_W, w_i.last, {11'b0, w_i}));
      end
      if (ar_valid_i && ar_ready_i) begin
        ar_q.push_back(make_flit(node_for(ar_i.addr), chimney_pkg::CH_AR, 1'b1, ar_i));
      end
      if (req_valid_i && req_ready_i) begin
        check_req(req_flit_i);
      end
      if (rsp_valid_i && rsp_ready_i) begin
        if (rsp_flit_i.hdr.axi_ch == chimney_pkg::CH_B) begin
          b_q.push_back(rsp_flit_i.payload[5:0]);
        end else if (rsp_flit_i.hdr.axi_ch == chimney_pkg::CH_R) begin
          r_q.push_back(rsp_flit_i.payload);
        end
      end
      if (b_valid_i && b_ready_i) begin
        if (b_q.size() == 0) begin
          failures++;
          $display("B beat at %0t has no response flit behind it", $time);
        end else begin
          exp_b = b_q.pop_front();
          if (b_i !== exp_b) begin
            mismatches++;
            $display("Mismatch at %0t: B beat expected %h, got %h", $time, exp_b, b_i);
          end
        end
      end
      if (r_valid_i && r_ready_i) begin
        if (r_q.size() == 0) begin
          failures++;
          $display("R beat at %0t has no response flit behind it", $time);
        end else begin
          exp_r = r_q.pop_front();
          if (r_i !== exp_r) begin
            mismatches++;
            $display("Mismatch at %0t: R beat expected %h, got %h", $time, exp_r, r_i);
          end
        end
      end
      // Anything still queued at the end was lost inside the DUT
      if (flush_i && !flushed) begin
        flushed = 1'b1;
        if (aww_q.size() + ar_q.size() + b_q.size() + r_q.size() != 0) begin
          failures++;
          $display("%0d AW/W, %0d AR, %0d B and %0d R items never left the DUT",
                   aww_q.size(), ar_q.size(), b_q.size(), r_q.size());
        end
      end
    end
  end

endmodule

`default_nettype wire

/* bench/chimney_tb.sv */
//////////////////////////////////////////////////////////////////////
// Chimney testbench
// Random AXI requests and response flits from an LFSR, with random
// back-pressure on every ready input
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "chimney_macros.svh"

module chimney_tb;

  localparam int NumAw   = 200;
  localparam int NumAr   = 200;
  localparam int NumRsp  = 300;
  localparam int NumTxn  = NumAw + NumAr + NumRsp;

  logic                       clk_i;
  logic                       reset_i;
  logic [`CHIMNEY_NODE_W-1:0] node_id_i;
  chimney_pkg::axi_aw_t       aw_i;
  logic                       aw_valid_i, aw_ready_o;
  chimney_pkg::axi_w_t        w_i;
  logic                       w_valid_i, w_ready_o;
  chimney_pkg::axi_ar_t       ar_i;
  logic                       ar_valid_i, ar_ready_o;
  chimney_pkg::axi_b_t        b_o;
  logic                       b_valid_o, b_ready_i;
  chimney_pkg::axi_r_t        r_o;
  logic                       r_valid_o, r_ready_i;
  chimney_pkg::req_flit_t     req_flit_o;
  logic                       req_valid_o, req_ready_i;
  chimney_pkg::rsp_flit_t     rsp_flit_i;
  logic                       rsp_valid_i, rsp_ready_o;
  logic                       flush;
  int                         mismatches, failures;
  int                         aw_todo, w_left, ar_todo, rsp_todo;
  logic [31:0]                lfsr_state;

  tb_clock clock_i (.clk_o(clk_i));

  axi_noc_chimney dut_i (.*);

  chimney_checker checker_i (
    .clk_i(clk_i), .reset_i(reset_i), .flush_i(flush), .node_id_i(node_id_i),
    .aw_i(aw_i), .aw_valid_i(aw_valid_i), .aw_ready_i(aw_ready_o),
    .w_i(w_i), .w_valid_i(w_valid_i), .w_ready_i(w_ready_o),
    .ar_i(ar_i), .ar_valid_i(ar_valid_i), .ar_ready_i(ar_ready_o),
    .req_flit_i(req_flit_o), .req_valid_i(req_valid_o), .req_ready_i(req_ready_i),
    .rsp_flit_i(rsp_flit_i), .rsp_valid_i(rsp_valid_i), .rsp_ready_i(rsp_ready_o),
    .b_i(b_o), .b_valid_i(b_valid_o), .b_ready_i(b_ready_i),
    .r_i(r_o), .r_valid_i(r_valid_o), .r_ready_i(r_ready_i),
    .mismatches_o(mismatches), .failures_o(failures)
  );

  bind axi_noc_chimney chimney_props props_i (
    .clk_i(clk_i), .reset_i(reset_i), .req_flit_i(req_flit_o),
    .req_valid_i(req_valid_o), .req_ready_i(req_ready_i), .rsp_valid_i(rsp_valid_i),
    .b_valid_i(b_valid_o), .r_valid_i(r_valid_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Random source
  //////////////////////////////////////////////////////////////////////

  // Galois LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] bits;
    bits = '0;
    for (int k = 0; k < n; k++) begin
      bits[k]    = lfsr_state[0];
      lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
    end
    return bits;
  endfunction

  // Mostly mapped, sometimes just above the map or anywhere
  function automatic logic [31:0] pick_addr();
    logic [1:0] kind;
    kind = 2'(take_bits(2));
    case (kind)
      2'd0:    return 32'(take_bits(32));
      2'd1:    return `CHIMNEY_MAP_BASE + 32'(take_bits(27));
      default: return `CHIMNEY_MAP_BASE + 32'(take_bits(26));
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic drive_cycle();
    chimney_pkg::axi_aw_t   aw_beat;
    chimney_pkg::axi_ar_t   ar_beat;
    chimney_pkg::rsp_flit_t flit;
    logic                   aw_busy, w_busy, ar_busy, rsp_busy;
    aw_busy  = aw_valid_i && !aw_ready_o;
    w_busy   = w_valid_i && !w_ready_o;
    ar_busy  = ar_valid_i && !ar_ready_o;
    rsp_busy = rsp_valid_i && !rsp_ready_o;
    req_ready_i <= (take_bits(2) != 0);
    b_ready_i   <= (take_bits(2) != 0);
    r_ready_i   <= (take_bits(2) != 0);
    if (aw_valid_i && aw_ready_o) begin
      aw_valid_i <= 1'b0;
      w_left = aw_i.len + 1;
    end
    if (w_valid_i && w_ready_o) begin
      w_valid_i <= 1'b0;
      w_left--;
    end
    if (ar_valid_i && ar_ready_o) ar_valid_i <= 1'b0;
    if (rsp_valid_i && rsp_ready_o) rsp_valid_i <= 1'b0;
    if (!aw_busy && !w_busy && w_left == 0 && aw_todo > 0 && take_bits(1)) begin
      aw_beat.id   = 4'(take_bits(4));
      aw_beat.addr = pick_addr();
      aw_beat.len  = 8'(take_bits(2));
      aw_i       <= aw_beat;
      aw_valid_i <= 1'b1;
      aw_todo--;
    end
    // W beats only follow an AW that has already transferred
    if (!w_busy && w_left > 0 && take_bits(1)) begin
      w_i       <= {32'(take_bits(32)), w_left == 1};
      w_valid_i <= 1'b1;
    end
    if (!ar_busy && ar_todo > 0 && take_bits(1)) begin
      ar_beat.id   = 4'(take_bits(4));
      ar_beat.addr = pick_addr();
      ar_beat.len  = 8'(take_bits(8));
      ar_i       <= ar_beat;
      ar_valid_i <= 1'b1;
      ar_todo--;
    end
    if (!rsp_busy && rsp_todo > 0 && take_bits(1)) begin
      flit.hdr.dst_id = 4'(take_bits(4));
      flit.hdr.src_id = 4'(take_bits(4));
      flit.hdr.last   = take_bits(1);
      flit.payload    = 39'(take_bits(39));
      case (2'(take_bits(2)))
        2'd0:    flit.hdr.axi_ch = chimney_pkg::CH_B;
        2'd3:    flit.hdr.axi_ch = chimney_pkg::CH_W;
        default: flit.hdr.axi_ch = chimney_pkg::CH_R;
      endcase
      rsp_flit_i  <= flit;
      rsp_valid_i <= 1'b1;
      rsp_todo--;
    end
  endtask

  function automatic logic all_done();
    return aw_todo == 0 && w_left == 0 && ar_todo == 0 && rsp_todo == 0 &&
           !aw_valid_i && !w_valid_i && !ar_valid_i && !rsp_valid_i;
  endfunction

  initial begin
    lfsr_state  = 32'h611f_e192;
    reset_i     = 1'b1;
    flush       = 1'b0;
    node_id_i   = 4'(take_bits(4));
    aw_i        = '0;
    aw_valid_i  = 1'b0;
    w_i         = '0;
    w_valid_i   = 1'b0;
    ar_i        = '0;
    ar_valid_i  = 1'b0;
    rsp_flit_i  = '0;
    rsp_valid_i = 1'b0;
    req_ready_i = 1'b0;
    b_ready_i   = 1'b0;
    r_ready_i   = 1'b0;
    aw_todo     = NumAw;
    ar_todo     = NumAr;
    rsp_todo    = NumRsp;
    w_left      = 0;
    repeat (16) @(posedge clk_i);
    reset_i <= 1'b0;
    forever begin
      @(posedge clk_i);
      if (all_done()) break;
      drive_cycle();
    end
    repeat (4) @(posedge clk_i);
    flush <= 1'b1;
    repeat (2) @(posedge clk_i);
    $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatches, failures, dut_i.props_i.assert_fails);
    if (mismatches + failures + dut_i.props_i.assert_fails == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Watchdog sized from the transaction count
  initial begin
    #(20 * NumTxn * 10);
    $display("Run timed out before all transactions completed");
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+logic
logic/chimney_pkg.sv
logic/addr_id_map.sv
logic/req_flit_packer.sv
logic/wormhole_arbiter.sv
logic/rsp_flit_unpacker.sv
logic/axi_noc_chimney.sv
bench/tb_clock.sv
bench/chimney_props.sv
bench/chimney_checker.sv
bench/chimney_tb.sv
